// ==== dv/dual_sram_model.sv ====
`default_nettype none

module dual_sram_model #(
    parameter int DEPTH      = 256,
    parameter int RD_LATENCY = fc_pkg::DEF_RD_LATENCY
) (
    input  logic          clk,
    input  logic          cen,
    input  fc_pkg::wea_t  wea0,
    input  fc_pkg::wea_t  wea1,
    input  fc_pkg::addr_t addr0,
    input  fc_pkg::addr_t addr1,
    input  fc_pkg::word_t wdata0,
    input  fc_pkg::word_t wdata1,
    output fc_pkg::word_t rdata0,
    output fc_pkg::word_t rdata1,
    // backdoor fill, port 0 side
    input  logic          fill_en,
    input  fc_pkg::addr_t fill_addr,
    input  fc_pkg::word_t fill_data
);
    localparam int AW = $clog2(DEPTH);

    fc_pkg::word_t mem [DEPTH];
    fc_pkg::word_t rd_pipe0 [RD_LATENCY];
    fc_pkg::word_t rd_pipe1 [RD_LATENCY];

    always @(posedge clk) begin
        if (fill_en) begin
            mem[fill_addr[AW-1:0]] <= fill_data;
        end
        if (!cen) begin
            for (int b = 0; b < 4; b++) begin
                if (wea0[b]) begin
                    mem[addr0[AW-1:0]][8*b +: 8] <= wdata0[8*b +: 8];
                end
                if (wea1[b]) begin
                    mem[addr1[AW-1:0]][8*b +: 8] <= wdata1[8*b +: 8];
                end
            end
        end
    end

    // read data appear RD_LATENCY cycles after the address
    always @(posedge clk) begin
        rd_pipe0[0] <= cen ? '0 : mem[addr0[AW-1:0]];
        rd_pipe1[0] <= cen ? '0 : mem[addr1[AW-1:0]];
        for (int i = 1; i < RD_LATENCY; i++) begin
            rd_pipe0[i] <= rd_pipe0[i-1];
            rd_pipe1[i] <= rd_pipe1[i-1];
        end
    end

    assign rdata0 = rd_pipe0[RD_LATENCY-1];
    assign rdata1 = rd_pipe1[RD_LATENCY-1];

endmodule

`default_nettype wire

// ==== dv/fc_layer_tb.sv ====
`default_nettype none

module fc_layer_tb;
    localparam int IN_WORDS      = fc_pkg::DEF_IN_WORDS;
    localparam int OUT_ROWS      = fc_pkg::DEF_OUT_ROWS;
    localparam int LANES         = fc_pkg::LANES_PER_WORD;
    localparam int RD_LATENCY    = 3;
    localparam int DEPTH         = 256;
    localparam int AW            = $clog2(DEPTH);
    localparam int IN_STEPS      = (IN_WORDS + 1) / 2;
    localparam int FINISH_CYCLES = 1 + OUT_ROWS * IN_STEPS + RD_LATENCY + OUT_ROWS / 2 + 2;
    localparam int HOLD_CYCLES   = 40;
    localparam int RUN_CYCLES    = 8 + DEPTH + 2 + FINISH_CYCLES + HOLD_CYCLES;
    localparam int WATCHDOG      = 3 * RUN_CYCLES + 200;

    logic          clk = 1'b0;
    logic          rst_n;
    logic          start;
    logic          finish;
    fc_pkg::addr_t weight_offset;
    fc_pkg::addr_t act_offset;
    logic          weight_cen;
    fc_pkg::addr_t weight_addr0;
    fc_pkg::addr_t weight_addr1;
    fc_pkg::word_t weight_rdata0;
    fc_pkg::word_t weight_rdata1;
    logic          act_cen;
    fc_pkg::wea_t  act_wea0;
    fc_pkg::wea_t  act_wea1;
    fc_pkg::addr_t act_addr0;
    fc_pkg::addr_t act_addr1;
    fc_pkg::word_t act_wdata0;
    fc_pkg::word_t act_wdata1;
    fc_pkg::word_t act_rdata0;
    fc_pkg::word_t act_rdata1;

    logic          fill_en;
    fc_pkg::addr_t fill_addr;
    fc_pkg::word_t wfill_data;
    fc_pkg::word_t afill_data;
    logic          idle_chk;
    int            errors = 0;
    int            checks = 0;
    integer        seed = 32'hc487_24a5;

    fc_pkg::word_t w_img [DEPTH];
    fc_pkg::word_t a_img [DEPTH];
    fc_pkg::word_t want_img [DEPTH];

    always #4 clk = ~clk;

    fc_layer #(
        .IN_WORDS   (IN_WORDS),
        .OUT_ROWS   (OUT_ROWS),
        .RD_LATENCY (RD_LATENCY)
    ) dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .finish        (finish),
        .weight_offset (weight_offset),
        .act_offset    (act_offset),
        .weight_cen    (weight_cen),
        .weight_addr0  (weight_addr0),
        .weight_addr1  (weight_addr1),
        .weight_rdata0 (weight_rdata0),
        .weight_rdata1 (weight_rdata1),
        .act_cen       (act_cen),
        .act_wea0      (act_wea0),
        .act_wea1      (act_wea1),
        .act_addr0     (act_addr0),
        .act_addr1     (act_addr1),
        .act_wdata0    (act_wdata0),
        .act_wdata1    (act_wdata1),
        .act_rdata0    (act_rdata0),
        .act_rdata1    (act_rdata1)
    );

    dual_sram_model #(.DEPTH(DEPTH), .RD_LATENCY(RD_LATENCY)) wram0 (
        .clk (clk), .cen (weight_cen), .wea0 ('0), .wea1 ('0),
        .addr0 (weight_addr0), .addr1 (weight_addr1), .wdata0 ('0), .wdata1 ('0),
        .rdata0 (weight_rdata0), .rdata1 (weight_rdata1),
        .fill_en (fill_en), .fill_addr (fill_addr), .fill_data (wfill_data)
    );

    dual_sram_model #(.DEPTH(DEPTH), .RD_LATENCY(RD_LATENCY)) aram0 (
        .clk (clk), .cen (act_cen), .wea0 (act_wea0), .wea1 (act_wea1),
        .addr0 (act_addr0), .addr1 (act_addr1), .wdata0 (act_wdata0), .wdata1 (act_wdata1),
        .rdata0 (act_rdata0), .rdata1 (act_rdata1),
        .fill_en (fill_en), .fill_addr (fill_addr), .fill_data (afill_data)
    );

    function automatic logic [AW-1:0] slot(input int a);
        return a[AW-1:0];
    endfunction

    function automatic int byte_of(input fc_pkg::word_t w, input int b);
        fc_pkg::lane_t v;
        v = fc_pkg::lane_t'(w >> (8 * b));
        return int'(v);
    endfunction

    function automatic bit in_window(input fc_pkg::addr_t a);
        fc_pkg::addr_t lo;
        lo = act_offset + fc_pkg::addr_t'(IN_WORDS);
        return (a >= lo) && (a < lo + fc_pkg::addr_t'(OUT_ROWS));
    endfunction

    // quiet while idle with start low
    assert property (@(posedge clk) disable iff (!rst_n)
        idle_chk |-> (weight_cen && act_cen && !finish && act_wea0 == '0 && act_wea1 == '0))
    else begin
        errors++;
        $display("FAIL %0t: engine active or finish high while idle", $time);
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        finish |-> (weight_cen && act_cen && act_wea0 == '0 && act_wea1 == '0))
    else begin
        errors++;
        $display("FAIL %0t: sram enabled after finish", $time);
    end

    assert property (@(posedge clk) disable iff (!rst_n) $past(finish) |-> finish)
    else begin
        errors++;
        $display("FAIL %0t: finish dropped before reset", $time);
    end

    // writes only into the result window
    assert property (@(posedge clk) disable iff (!rst_n)
        (!act_cen && (act_wea0 != '0 || act_wea1 != '0))
            |-> (in_window(act_addr0) && in_window(act_addr1)))
    else begin
        errors++;
        $display("FAIL %0t: write outside result window at %0d/%0d", $time,
                 act_addr0, act_addr1);
    end

    task automatic apply_reset();
        @(negedge clk);
        rst_n    = 1'b0;
        start    = 1'b0;
        idle_chk = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic build_images(input bit all_min, input int woff, input int aoff);
        for (int i = 0; i < DEPTH; i++) begin
            if (all_min) begin
                // address pattern outside the operands
                w_img[slot(i)] = {8'(i), 8'h3c, 8'(~i), 8'hc3};
                a_img[slot(i)] = {8'(~i), 8'h5a, 8'(i), 8'ha5};
            end else begin
                w_img[slot(i)] = $random(seed);
                a_img[slot(i)] = $random(seed);
            end
        end
        if (all_min) begin
            for (int i = 0; i < OUT_ROWS * IN_WORDS; i++) begin
                w_img[slot(woff + i)] = 32'h8080_8080;
            end
            for (int i = 0; i < IN_WORDS; i++) begin
                a_img[slot(aoff + i)] = 32'h8080_8080;
            end
            // word past the last row must never be used
            w_img[slot(woff + OUT_ROWS * IN_WORDS)] = 32'h0172_7f05;
        end
    endtask

    task automatic load_memories();
        idle_chk = 1'b1;
        for (int i = 0; i < DEPTH; i++) begin
            @(negedge clk);
            fill_en    = 1'b1;
            fill_addr  = fc_pkg::addr_t'(i);
            wfill_data = w_img[slot(i)];
            afill_data = a_img[slot(i)];
        end
        @(negedge clk);
        fill_en = 1'b0;
    endtask

    // row r is the signed sum over all 84 byte pairs
    task automatic compute_expected(input int woff, input int aoff);
        int acc;
        int j;
        for (int i = 0; i < DEPTH; i++) begin
            want_img[slot(i)] = a_img[slot(i)];
        end
        for (int r = 0; r < OUT_ROWS; r++) begin
            acc = 0;
            for (int k = 0; k < IN_WORDS * LANES; k++) begin
                j = k / LANES;
                acc += byte_of(w_img[slot(woff + r * IN_WORDS + j)], k % LANES)
                     * byte_of(a_img[slot(aoff + j)], k % LANES);
            end
            want_img[slot(aoff + IN_WORDS + r)] = acc;
        end
    endtask

    task automatic run_layer(input int woff, input int aoff);
        int n;
        @(negedge clk);
        weight_offset = fc_pkg::addr_t'(woff);
        act_offset    = fc_pkg::addr_t'(aoff);
        idle_chk      = 1'b0;
        start         = 1'b1;
        @(negedge clk);
        start = 1'b0;
        // edges counted after the one that sampled start
        n = 0;
        while (!finish && n < 2 * FINISH_CYCLES) begin
            @(negedge clk);
            n++;
        end
        checks++;
        if (!finish) begin
            errors++;
            $display("finish did not rise within %0d cycles of start", n);
        end else begin
            assert (n == FINISH_CYCLES)
            else begin
                errors++;
                $display("FAIL %0t: finish after %0d cycles, expected %0d", $time, n,
                         FINISH_CYCLES);
            end
        end
    endtask

    task automatic check_results();
        repeat (HOLD_CYCLES) @(negedge clk);
        for (int i = 0; i < DEPTH; i++) begin
            checks++;
            assert (aram0.mem[slot(i)] == want_img[slot(i)])
            else begin
                errors++;
                $display("FAIL %0t: act word %0d is %h, expected %h", $time, i,
                         aram0.mem[slot(i)], want_img[slot(i)]);
            end
        end
    endtask

    task automatic run_case(input bit all_min, input int woff, input int aoff);
        apply_reset();
        build_images(all_min, woff, aoff);
        load_memories();
        compute_expected(woff, aoff);
        run_layer(woff, aoff);
        check_results();
    endtask

    initial begin
        rst_n         = 1'b0;
        start         = 1'b0;
        weight_offset = '0;
        act_offset    = '0;
        fill_en       = 1'b0;
        fill_addr     = '0;
        wfill_data    = '0;
        afill_data    = '0;
        idle_chk      = 1'b0;
        run_case(1'b0, 0, 0);
        // every product is -128 * -128
        run_case(1'b1, 0, 0);
        run_case(1'b0, 20, 100);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG * 8);
        $display("timeout: the run did not end within %0d cycles", WATCHDOG);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/acc_ctrl_if.sv ====
`default_nettype none

interface acc_ctrl_if #(
    parameter int OUT_ROWS = fc_pkg::DEF_OUT_ROWS
);
    localparam int ROW_W = $clog2(OUT_ROWS + 1);

    logic             clear;
    logic             acc_en;
    logic [ROW_W-1:0] acc_row;
    logic             acc_tail;
    logic [ROW_W-1:0] drain_idx;
    fc_pkg::psum_t    sum_even;
    fc_pkg::psum_t    sum_odd;

    modport seq (
        output clear, acc_en, acc_row, acc_tail, drain_idx
    );

    modport bank (
        input  clear, acc_en, acc_row, acc_tail, drain_idx,
        output sum_even, sum_odd
    );

endinterface

`default_nettype wire

// ==== hdl/dot8.sv ====
`default_nettype none

module dot8 (
    input  fc_pkg::word_t weight_lo,
    input  fc_pkg::word_t weight_hi,
    input  fc_pkg::word_t act_lo,
    input  fc_pkg::word_t act_hi,
    output fc_pkg::psum_t sum
);
    localparam int LW    = $bits(fc_pkg::lane_t);
    localparam int NW    = fc_pkg::LANES_PER_WORD;
    localparam int LANES = 2 * NW;

    fc_pkg::lane_t      w [LANES];
    fc_pkg::lane_t      a [LANES];
    logic signed [15:0] prod [LANES];
    logic signed [16:0] pair [LANES/2];
    logic signed [17:0] quad [LANES/4];

    always_comb begin
        // byte k of weight pairs with byte k of activation
        for (int k = 0; k < NW; k++) begin
            w[k]      = weight_lo[LW*k +: LW];
            w[k + NW] = weight_hi[LW*k +: LW];
            a[k]      = act_lo[LW*k +: LW];
            a[k + NW] = act_hi[LW*k +: LW];
        end
        for (int k = 0; k < LANES; k++) begin
            prod[k] = w[k] * a[k];
        end
        // adder tree
        for (int k = 0; k < LANES/2; k++) begin
            pair[k] = prod[2*k] + prod[2*k + 1];
        end
        for (int k = 0; k < LANES/4; k++) begin
            quad[k] = pair[2*k] + pair[2*k + 1];
        end
        sum = quad[0] + quad[1];
    end

endmodule

`default_nettype wire

// ==== hdl/fc_layer.sv ====
`default_nettype none

module fc_layer #(
    parameter int IN_WORDS   = fc_pkg::DEF_IN_WORDS,
    parameter int OUT_ROWS   = fc_pkg::DEF_OUT_ROWS,
    parameter int RD_LATENCY = fc_pkg::DEF_RD_LATENCY
) (
    input  logic          clk,
    input  logic          rst_n,

    input  logic          start,
    output logic          finish,
    input  fc_pkg::addr_t weight_offset,
    input  fc_pkg::addr_t act_offset,

    // weight sram, read only
    output logic          weight_cen,
    output fc_pkg::addr_t weight_addr0,
    output fc_pkg::addr_t weight_addr1,
    input  fc_pkg::word_t weight_rdata0,
    input  fc_pkg::word_t weight_rdata1,

    // activation sram, dual port
    output logic          act_cen,
    output fc_pkg::wea_t  act_wea0,
    output fc_pkg::wea_t  act_wea1,
    output fc_pkg::addr_t act_addr0,
    output fc_pkg::addr_t act_addr1,
    output fc_pkg::word_t act_wdata0,
    output fc_pkg::word_t act_wdata1,
    input  fc_pkg::word_t act_rdata0,
    input  fc_pkg::word_t act_rdata1
);

    acc_ctrl_if #(
        .OUT_ROWS (OUT_ROWS)
    ) ctrl0 ();

    fc_sequencer #(
        .IN_WORDS   (IN_WORDS),
        .OUT_ROWS   (OUT_ROWS),
        .RD_LATENCY (RD_LATENCY)
    ) seq0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .weight_offset (weight_offset),
        .act_offset    (act_offset),
        .finish        (finish),
        .weight_cen    (weight_cen),
        .weight_addr0  (weight_addr0),
        .weight_addr1  (weight_addr1),
        .act_cen       (act_cen),
        .act_wea0      (act_wea0),
        .act_wea1      (act_wea1),
        .act_addr0     (act_addr0),
        .act_addr1     (act_addr1),
        .ctrl          (ctrl0.seq)
    );

    // read data go straight into the datapath
    psum_bank #(
        .OUT_ROWS (OUT_ROWS)
    ) bank0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .weight_word0 (weight_rdata0),
        .weight_word1 (weight_rdata1),
        .act_word0    (act_rdata0),
        .act_word1    (act_rdata1),
        .ctrl         (ctrl0.bank),
        .wdata0       (act_wdata0),
        .wdata1       (act_wdata1)
    );

endmodule

`default_nettype wire

// ==== hdl/fc_pkg.sv ====
`default_nettype none

package fc_pkg;

    // sram side
    typedef logic [15:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  wea_t;

    // datapath side
    typedef logic signed [7:0]  lane_t;
    typedef logic signed [31:0] psum_t;

    localparam int LANES_PER_WORD = 4;

    // default layer geometry, 84 inputs by 10 outputs
    localparam int DEF_IN_WORDS   = 21;
    // must be even, rows drain in pairs
    localparam int DEF_OUT_ROWS   = 10;
    // address cycle to consume cycle
    localparam int DEF_RD_LATENCY = 3;

endpackage

`default_nettype wire

// ==== hdl/fc_sequencer.sv ====
`default_nettype none

module fc_sequencer #(
    parameter int IN_WORDS   = fc_pkg::DEF_IN_WORDS,
    parameter int OUT_ROWS   = fc_pkg::DEF_OUT_ROWS,
    parameter int RD_LATENCY = fc_pkg::DEF_RD_LATENCY
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          start,
    input  fc_pkg::addr_t weight_offset,
    input  fc_pkg::addr_t act_offset,
    output logic          finish,
    output logic          weight_cen,
    output fc_pkg::addr_t weight_addr0,
    output fc_pkg::addr_t weight_addr1,
    output logic          act_cen,
    output fc_pkg::wea_t  act_wea0,
    output fc_pkg::wea_t  act_wea1,
    output fc_pkg::addr_t act_addr0,
    output fc_pkg::addr_t act_addr1,
    acc_ctrl_if.seq       ctrl
);
    localparam int IN_STEPS      = (IN_WORDS + 1) / 2;
    localparam int SETTLE_CYCLES = 2;
    localparam int CNT_MAX       = (IN_STEPS > RD_LATENCY) ? IN_STEPS : RD_LATENCY;
    localparam int STEP_W        = $clog2(CNT_MAX + 1);
    localparam int ROW_W         = $clog2(OUT_ROWS + 1);
    localparam bit ODD_WORDS     = (IN_WORDS % 2) == 1;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_FLUSH,
        ST_DRAIN,
        ST_SETTLE,
        ST_DONE
    } state_t;

    state_t            state;
    logic [STEP_W-1:0] step;
    logic [ROW_W-1:0]  row;
    logic              last_step;
    logic              last_row;
    logic              load_tail;
    fc_pkg::addr_t     step_addr;
    fc_pkg::addr_t     row_base;
    fc_pkg::addr_t     load_waddr;
    fc_pkg::addr_t     load_aaddr;
    fc_pkg::addr_t     drain_addr;

    // read latency delay line
    logic [RD_LATENCY-1:0] vld_pipe;
    logic [RD_LATENCY-1:0] tail_pipe;
    logic [ROW_W-1:0]      row_pipe [RD_LATENCY];

    assign last_step = step == STEP_W'(IN_STEPS - 1);
    assign last_row  = row == ROW_W'(OUT_ROWS - 1);
    assign load_tail = ODD_WORDS && last_step;

    assign step_addr  = fc_pkg::addr_t'({step, 1'b0});
    assign row_base   = fc_pkg::addr_t'(row) * fc_pkg::addr_t'(IN_WORDS);
    assign load_waddr = weight_offset + row_base + step_addr;
    assign load_aaddr = act_offset + step_addr;
    // results go right after the input vector
    assign drain_addr = act_offset + fc_pkg::addr_t'(IN_WORDS) + fc_pkg::addr_t'(row);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= ST_IDLE;
            step   <= '0;
            row    <= '0;
            finish <= 1'b0;
        end else begin
            // done is sticky until reset
            finish <= state == ST_DONE;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_LOAD;
                        step  <= '0;
                        row   <= '0;
                    end
                end
                ST_LOAD: begin
                    if (last_step) begin
                        step <= '0;
                        if (last_row) begin
                            state <= ST_FLUSH;
                            row   <= '0;
                        end else begin
                            row <= row + ROW_W'(1);
                        end
                    end else begin
                        step <= step + STEP_W'(1);
                    end
                end
                ST_FLUSH: begin
                    // wait out the reads still in flight
                    if (step == STEP_W'(RD_LATENCY - 1)) begin
                        state <= ST_DRAIN;
                        step  <= '0;
                    end else begin
                        step <= step + STEP_W'(1);
                    end
                end
                ST_DRAIN: begin
                    if (row == ROW_W'(OUT_ROWS - 2)) begin
                        state <= ST_SETTLE;
                        row   <= '0;
                    end else begin
                        row <= row + ROW_W'(2);
                    end
                end
                ST_SETTLE: begin
                    if (step == STEP_W'(SETTLE_CYCLES - 1)) begin
                        state <= ST_DONE;
                        step  <= '0;
                    end else begin
                        step <= step + STEP_W'(1);
                    end
                end
                ST_DONE: begin
                    state <= ST_DONE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_comb begin
        weight_cen   = 1'b1;
        weight_addr0 = '0;
        weight_addr1 = '0;
        act_cen      = 1'b1;
        act_wea0     = '0;
        act_wea1     = '0;
        act_addr0    = '0;
        act_addr1    = '0;
        case (state)
            ST_LOAD: begin
                weight_cen   = 1'b0;
                weight_addr0 = load_waddr;
                weight_addr1 = load_waddr + fc_pkg::addr_t'(1);
                act_cen      = 1'b0;
                act_addr0    = load_aaddr;
                act_addr1    = load_aaddr + fc_pkg::addr_t'(1);
            end
            ST_DRAIN: begin
                act_cen   = 1'b0;
                act_wea0  = '1;
                act_wea1  = '1;
                act_addr0 = drain_addr;
                act_addr1 = drain_addr + fc_pkg::addr_t'(1);
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= state == ST_LOAD;
            for (int i = 1; i < RD_LATENCY; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        tail_pipe[0] <= load_tail;
        row_pipe[0]  <= row;
        for (int i = 1; i < RD_LATENCY; i++) begin
            tail_pipe[i] <= tail_pipe[i-1];
            row_pipe[i]  <= row_pipe[i-1];
        end
    end

    assign ctrl.clear     = (state == ST_IDLE) && start;
    assign ctrl.acc_en    = vld_pipe[RD_LATENCY-1];
    assign ctrl.acc_row   = row_pipe[RD_LATENCY-1];
    assign ctrl.acc_tail  = tail_pipe[RD_LATENCY-1];
    assign ctrl.drain_idx = row;

endmodule

`default_nettype wire

// ==== hdl/psum_bank.sv ====
`default_nettype none

module psum_bank #(
    parameter int OUT_ROWS = fc_pkg::DEF_OUT_ROWS
) (
    input  logic          clk,
    input  logic          rst_n,
    input  fc_pkg::word_t weight_word0,
    input  fc_pkg::word_t weight_word1,
    input  fc_pkg::word_t act_word0,
    input  fc_pkg::word_t act_word1,
    acc_ctrl_if.bank      ctrl,
    output fc_pkg::word_t wdata0,
    output fc_pkg::word_t wdata1
);
    localparam int ROW_W = $clog2(OUT_ROWS + 1);

    fc_pkg::psum_t    sums [OUT_ROWS];
    fc_pkg::word_t    weight_hi;
    fc_pkg::word_t    act_hi;
    fc_pkg::psum_t    dot;
    logic [ROW_W-1:0] odd_idx;

    // last step of a row only has one valid word pair
    assign weight_hi = ctrl.acc_tail ? '0 : weight_word1;
    assign act_hi    = ctrl.acc_tail ? '0 : act_word1;

    dot8 dot0 (
        .weight_lo (weight_word0),
        .weight_hi (weight_hi),
        .act_lo    (act_word0),
        .act_hi    (act_hi),
        .sum       (dot)
    );

    always_ff @(posedge clk) begin
        if (!rst_n || ctrl.clear) begin
            for (int r = 0; r < OUT_ROWS; r++) begin
                sums[r] <= '0;
            end
        end else if (ctrl.acc_en) begin
            sums[ctrl.acc_row] <= sums[ctrl.acc_row] + dot;
        end
    end

    // drain reads a row pair
    assign odd_idx       = ctrl.drain_idx + ROW_W'(1);
    assign ctrl.sum_even = sums[ctrl.drain_idx];
    assign ctrl.sum_odd  = sums[odd_idx];

    assign wdata0 = ctrl.sum_even;
    assign wdata1 = ctrl.sum_odd;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the fc_layer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module fc_layer_tb \
    -Mdir obj_dir \
    -o fc_layer_tb_sim

./obj_dir/fc_layer_tb_sim 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run.sh: simulation reported failure"
    exit 1
fi
echo "run.sh: simulation passed"
exit 0

// ==== vlog.f ====
hdl/fc_pkg.sv
hdl/acc_ctrl_if.sv
hdl/dot8.sv
hdl/psum_bank.sv
hdl/fc_sequencer.sv
hdl/fc_layer.sv
dv/dual_sram_model.sv
dv/fc_layer_tb.sv
